/* source/alu_data_pkg.sv */
/*
  ALU data types
  data word, flag set and the registered bus output word
*/
package alu_data_pkg;

  // datapath width in bits
  localparam int word_width = 16;

  // one data word, used for operands, result and Q
  typedef logic [word_width-1:0] word_t;

  // condition flags as kept by the status register
  typedef struct packed {
    logic carry;  // adder carry out of the msb
    logic ovf;    // two's complement overflow
    logic zero;   // shifted result is all zero
    logic sign;   // msb of the shifted result
  } flags_t;

  // what leaves the datapath one cycle after a strobe
  typedef struct packed {
    word_t  data;   // selected source word
    flags_t flags;  // flags after this microinstruction
  } bus_out_t;

endpackage

/* source/alu_ops_pkg.sv */
/*
  ALU microinstruction encodings
  field codes for the operand pair, function, destination, carry in,
  shift fill and bus source, and the microinstruction word itself
*/
package alu_ops_pkg;
  import alu_data_pkg::*;

  // R and S operand pairs, as in the classic bit-slice parts
  typedef enum logic [2:0] {
    r_a_s_q    = 3'd0,
    r_a_s_b    = 3'd1,
    r_zero_s_q = 3'd2,
    r_zero_s_b = 3'd3,
    r_zero_s_a = 3'd4,
    r_d_s_a    = 3'd5,
    r_d_s_q    = 3'd6,
    r_d_s_zero = 3'd7
  } src_sel_e;

  // function codes, code 7 is unused
  typedef enum logic [2:0] {
    f_add    = 3'd0,  // r + s + cin
    f_subr   = 3'd1,  // s + ~r + cin
    f_subs   = 3'd2,  // r + ~s + cin
    f_or     = 3'd3,
    f_and    = 3'd4,
    f_xor    = 3'd5,
    f_pass_s = 3'd6
  } func_e;

  // destination and shift control
  typedef enum logic [2:0] {
    d_none   = 3'd0,  // y = f
    d_load_q = 3'd1,  // q = f, y = f
    d_shr    = 3'd2,  // y = f >> 1
    d_shl    = 3'd3,  // y = f << 1, zero fill
    d_dshr   = 3'd4   // {f,q} >> 1 as one double word
  } dest_e;

  // carry into the adder
  typedef enum logic [1:0] {
    c_zero = 2'd0,
    c_one  = 2'd1,
    c_flag = 2'd2   // stored carry flag
  } cin_sel_e;

  // bit shifted into the msb on right shifts
  typedef enum logic [1:0] {
    s_zero  = 2'd0,
    s_sign  = 2'd1,  // f bit 15
    s_carry = 2'd2   // stored carry flag
  } fill_sel_e;

  // internal data bus source
  typedef enum logic [1:0] {
    b_result = 2'd0,  // shifted result y
    b_q      = 2'd1,  // q before this update
    b_flags  = 2'd2,  // flags before this update, in the low bits
    b_d      = 2'd3   // the d field passed straight through
  } bus_sel_e;

  // one microinstruction
  typedef struct packed {
    src_sel_e  src;
    func_e     func;
    dest_e     dest;
    cin_sel_e  cin;
    fill_sel_e fill;
    bus_sel_e  bus;
    logic      set_flags;
    word_t     d;
  } alu_uop_t;

endpackage

/* source/alu_core.sv */
/*
  ALU core
  operand selection, carry in choice and the function unit,
  with adder carry and overflow out, all combinational
*/
`timescale 1ns/1ps

module alu_core import alu_data_pkg::*, alu_ops_pkg::*; (
  input  alu_uop_t uop,
  input  word_t    a,
  input  word_t    b,
  input  word_t    q,
  input  flags_t   flags,
  output word_t    f,
  output logic     carry_out,
  output logic     ovf_out
);

  word_t               r;
  word_t               s;
  word_t               op_x;
  word_t               op_y;
  logic                cin;
  logic                arith;
  logic [word_width:0] sum;

  // r operand from the source pair
  always_comb begin : r_mux
    case (uop.src)
      r_a_s_q, r_a_s_b:                     r = a;
      r_d_s_a, r_d_s_q, r_d_s_zero:         r = uop.d;
      default:                              r = '0;
    endcase
  end

  // s operand from the source pair
  always_comb begin : s_mux
    case (uop.src)
      r_a_s_q, r_zero_s_q, r_d_s_q:         s = q;
      r_a_s_b, r_zero_s_b:                  s = b;
      r_zero_s_a, r_d_s_a:                  s = a;
      default:                              s = '0;
    endcase
  end

  always_comb begin : cin_mux
    case (uop.cin)
      c_zero:  cin = 1'b0;
      c_one:   cin = 1'b1;
      c_flag:  cin = flags.carry;
      default: cin = 1'b0;
    endcase
  end

  // subtraction inverts one adder input, the carry in completes it
  always_comb begin : adder_inputs
    op_x  = r;
    op_y  = s;
    arith = 1'b1;
    case (uop.func)
      f_add:   arith = 1'b1;
      f_subr:  op_x = ~r;
      f_subs:  op_y = ~s;
      default: arith = 1'b0;
    endcase
  end

  assign sum = {1'b0, op_x} + {1'b0, op_y} + {{word_width{1'b0}}, cin};

  always_comb begin : func_unit
    case (uop.func)
      f_or:     f = r | s;
      f_and:    f = r & s;
      f_xor:    f = r ^ s;
      f_pass_s: f = s;
      default:  f = sum[word_width-1:0];
    endcase
  end

  // logic functions report no carry and no overflow
  assign carry_out = arith & sum[word_width];
  // same input signs but a different result sign
  assign ovf_out = arith & (op_x[word_width-1] == op_y[word_width-1]) &
                   (sum[word_width-1] != op_x[word_width-1]);

endmodule

/* source/alu_shift_q.sv */
/*
  ALU shifter and Q register
  forms y from f by the destination code, and keeps Q with load
  and double right shift, written only on a strobe
*/
`timescale 1ns/1ps

module alu_shift_q import alu_data_pkg::*, alu_ops_pkg::*; (
  input  logic      aluclk,
  input  logic      rst,
  input  logic      uop_valid,
  input  dest_e     dest,
  input  fill_sel_e fill,
  input  logic      carry,
  input  word_t     f,
  output word_t     y,
  output word_t     q
);

  logic  fill_bit;
  word_t q_next;

  // bit entering the msb on a right shift
  always_comb begin : fill_mux
    case (fill)
      s_zero:  fill_bit = 1'b0;
      s_sign:  fill_bit = f[word_width-1];
      s_carry: fill_bit = carry;
      default: fill_bit = 1'b0;
    endcase
  end

  always_comb begin : shifter
    y      = f;
    q_next = q;
    case (dest)
      d_none:   y = f;
      d_load_q: q_next = f;
      d_shr:    y = {fill_bit, f[word_width-1:1]};
      // left shift always brings in zero
      d_shl:    y = {f[word_width-2:0], 1'b0};
      d_dshr: begin
        // f lsb drops into the q msb
        y      = {fill_bit, f[word_width-1:1]};
        q_next = {f[0], q[word_width-1:1]};
      end
      default:  y = f;
    endcase
  end

  // q holds unless a strobe carries a q destination
  always_ff @(posedge aluclk) begin
    if (rst) begin
      q <= '0;
    end else if (uop_valid) begin
      q <= q_next;
    end
  end

endmodule

/* source/alu_status.sv */
/*
  ALU status flags
  builds the next flag set from the adder and the shifted result,
  and loads it on a strobe that asks for a flag update
*/
`timescale 1ns/1ps

module alu_status import alu_data_pkg::*; (
  input  logic   aluclk,
  input  logic   rst,
  input  logic   uop_valid,
  input  logic   set_flags,
  input  logic   carry_out,
  input  logic   ovf_out,
  input  word_t  y,
  output flags_t next_flags,
  output flags_t flags
);

  logic load;

  assign load = uop_valid & set_flags;

  // zero and sign look at y, after the shifter
  always_comb begin : flag_gen
    next_flags.carry = carry_out;
    next_flags.ovf   = ovf_out;
    next_flags.zero  = (y == '0);
    next_flags.sign  = y[word_width-1];
  end

  always_ff @(posedge aluclk) begin
    if (rst) begin
      flags <= '0;
    end else if (load) begin
      flags <= next_flags;
    end
  end

endmodule

/* source/alu_outmux.sv */
/*
  ALU output mux
  registers the selected bus source with the flags after this
  microinstruction, and raises bus_valid one cycle after a strobe
*/
`timescale 1ns/1ps

module alu_outmux import alu_data_pkg::*, alu_ops_pkg::*; (
  input  logic     aluclk,
  input  logic     rst,
  input  logic     uop_valid,
  input  bus_sel_e bus,
  input  logic     set_flags,
  input  word_t    y,
  input  word_t    q,
  input  word_t    d,
  input  flags_t   next_flags,
  input  flags_t   flags,
  output bus_out_t bus_out,
  output logic     bus_valid
);

  word_t  sel_word;
  flags_t sel_flags;

  // q and flags here are still the values from before this edge
  always_comb begin : word_mux
    case (bus)
      b_result: sel_word = y;
      b_q:      sel_word = q;
      b_flags:  sel_word = {{(word_width - $bits(flags_t)){1'b0}}, flags};
      b_d:      sel_word = d;
      default:  sel_word = y;
    endcase
  end

  // flags as they will be after the edge
  assign sel_flags = set_flags ? next_flags : flags;

  always_ff @(posedge aluclk) begin
    if (rst) begin
      bus_valid <= 1'b0;
      bus_out   <= '0;
    end else begin
      bus_valid <= uop_valid;
      // output word only moves when a result is produced
      if (uop_valid) begin
        bus_out.data  <= sel_word;
        bus_out.flags <= sel_flags;
      end
    end
  end

endmodule

/* source/alu_top.sv */
/*
  ALU datapath top
  core, shifter with Q, status flags and output mux,
  one result out per microinstruction strobe
*/
`timescale 1ns/1ps

module alu_top import alu_data_pkg::*, alu_ops_pkg::*; (
  input  logic     aluclk,
  input  logic     rst,
  input  logic     uop_valid,
  input  alu_uop_t uop,
  input  word_t    a,
  input  word_t    b,
  output bus_out_t bus_out,
  output logic     bus_valid
);

  word_t  f;
  word_t  y;
  word_t  q;
  logic   carry_out;
  logic   ovf_out;
  flags_t next_flags;
  flags_t flags;

  alu_core i_alu_core (
    .uop       (uop),
    .a         (a),
    .b         (b),
    .q         (q),
    .flags     (flags),
    .f         (f),
    .carry_out (carry_out),
    .ovf_out   (ovf_out)
  );

  // right shift fill uses the stored carry, not this cycle's
  alu_shift_q i_alu_shift_q (
    .aluclk    (aluclk),
    .rst       (rst),
    .uop_valid (uop_valid),
    .dest      (uop.dest),
    .fill      (uop.fill),
    .carry     (flags.carry),
    .f         (f),
    .y         (y),
    .q         (q)
  );

  alu_status i_alu_status (
    .aluclk     (aluclk),
    .rst        (rst),
    .uop_valid  (uop_valid),
    .set_flags  (uop.set_flags),
    .carry_out  (carry_out),
    .ovf_out    (ovf_out),
    .y          (y),
    .next_flags (next_flags),
    .flags      (flags)
  );

  alu_outmux i_alu_outmux (
    .aluclk     (aluclk),
    .rst        (rst),
    .uop_valid  (uop_valid),
    .bus        (uop.bus),
    .set_flags  (uop.set_flags),
    .y          (y),
    .q          (q),
    .d          (uop.d),
    .next_flags (next_flags),
    .flags      (flags),
    .bus_out    (bus_out),
    .bus_valid  (bus_valid)
  );

endmodule

/* bench/alu_clock.sv */
/*
  ALU testbench clock and reset
  10 ns clock, reset held high for the first 10 cycles
*/
`timescale 1ns/1ps

module alu_clock (
  output logic aluclk,
  output logic rst
);

  // free running, 5 ns per half period
  initial begin
    aluclk = 1'b0;
    forever begin
      #5 aluclk = ~aluclk;
    end
  end

  // synchronous reset, released on a rising edge
  initial begin
    rst <= 1'b1;
    repeat (10) @(posedge aluclk);
    rst <= 1'b0;
  end

endmodule

/* bench/alu_properties.sv */
/*
  ALU datapath timing properties
  bus_valid follows each strobe by exactly one cycle, and the bus
  output stays quiet after reset and between results
*/
`timescale 1ns/1ps

module alu_properties import alu_data_pkg::*; (
  input logic     aluclk,
  input logic     rst,
  input logic     uop_valid,
  input bus_out_t bus_out,
  input logic     bus_valid
);

  logic seen_uop;

  // set by the first strobe after reset
  always_ff @(posedge aluclk) begin
    if (rst) begin
      seen_uop <= 1'b0;
    end else if (uop_valid) begin
      seen_uop <= 1'b1;
    end
  end

  // reset clears valid and the output word
  reset_clears: assert property (@(posedge aluclk) rst |=> !bus_valid && bus_out == '0)
    else $error("bus output not cleared by reset");

  // nothing leaves the datapath until a microinstruction arrives
  quiet_before_first: assert property (@(posedge aluclk) disable iff (rst)
    !seen_uop |-> !bus_valid && bus_out == '0)
    else $error("bus output active before the first strobe");

  // one result per strobe, back to back included
  valid_after_uop: assert property (@(posedge aluclk) disable iff (rst)
    uop_valid |=> bus_valid)
    else $error("bus_valid missing one cycle after a strobe");

  valid_only_after_uop: assert property (@(posedge aluclk) disable iff (rst)
    !uop_valid |=> !bus_valid)
    else $error("bus_valid high without a strobe the cycle before");

  // output word moves only with a result
  out_holds: assert property (@(posedge aluclk) disable iff (rst)
    !uop_valid |=> bus_out == $past(bus_out))
    else $error("bus output changed without a result");

endmodule

bind alu_top alu_properties i_alu_properties (
  .aluclk    (aluclk),
  .rst       (rst),
  .uop_valid (uop_valid),
  .bus_out   (bus_out),
  .bus_valid (bus_valid)
);

/* bench/alu_tb.sv */
/*
  ALU datapath testbench
  random microinstructions from an LFSR, a reference model of Q and
  the flags, and a check of every bus output against the model
*/
`timescale 1ns/1ps

module alu_tb import alu_data_pkg::*, alu_ops_pkg::*; ();

  localparam int num_uops = 400;
  // at most a few cycles per strobe with its gaps, plus reset
  localparam int timeout_cycles = num_uops * 3 + 50;

  logic     aluclk;
  logic     rst;
  logic     uop_valid = 1'b0;
  alu_uop_t uop = '0;
  word_t    a = '0;
  word_t    b = '0;
  bus_out_t bus_out;
  logic     bus_valid;

  // 17 bits so the seed fits, taps 17 and 14
  logic [16:0] lfsr_state = 17'd78977;
  word_t       model_q;
  flags_t      model_flags;
  bus_out_t    expected[$];
  int          cycle_count = 0;

  alu_clock i_alu_clock (
    .aluclk (aluclk),
    .rst    (rst)
  );

  alu_top i_alu_top (
    .aluclk    (aluclk),
    .rst       (rst),
    .uop_valid (uop_valid),
    .uop       (uop),
    .a         (a),
    .b         (b),
    .bus_out   (bus_out),
    .bus_valid (bus_valid)
  );

  function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  // one LFSR step per bit taken
  task automatic take_bits(input int n, output word_t val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[word_width-2:0], lfsr_state[0]};
    end
  endtask

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "run stopped on the first error");
  endtask

  task automatic random_uop(output alu_uop_t u, output word_t av, output word_t bv);
    word_t raw;
    take_bits(3, raw);
    u.src = src_sel_e'(raw[2:0]);
    // codes past the last one wrap back into range
    take_bits(3, raw);
    u.func = func_e'(3'(raw % 16'd7));
    take_bits(3, raw);
    u.dest = dest_e'(3'(raw % 16'd5));
    take_bits(2, raw);
    u.cin = cin_sel_e'(2'(raw % 16'd3));
    take_bits(2, raw);
    u.fill = fill_sel_e'(2'(raw % 16'd3));
    take_bits(2, raw);
    u.bus = bus_sel_e'(raw[1:0]);
    take_bits(1, raw);
    u.set_flags = raw[0];
    take_bits(16, raw);
    u.d = raw;
    take_bits(16, av);
    take_bits(16, bv);
  endtask

  // reference model, advances its own Q and flags by one microinstruction
  task automatic model_uop(input alu_uop_t u, input word_t av, input word_t bv,
                           output bus_out_t exp);
    logic [31:0] rs;
    word_t       r;
    word_t       s;
    word_t       fv;
    word_t       yv;
    word_t       q_new;
    logic        c;
    logic        fill_bit;
    logic [16:0] tot;
    int          sres;
    flags_t      nf;
    // R in the upper half, S in the lower half
    case (u.src)
      r_a_s_q:    rs = {av, model_q};
      r_a_s_b:    rs = {av, bv};
      r_zero_s_q: rs = {16'h0, model_q};
      r_zero_s_b: rs = {16'h0, bv};
      r_zero_s_a: rs = {16'h0, av};
      r_d_s_a:    rs = {u.d, av};
      r_d_s_q:    rs = {u.d, model_q};
      default:    rs = {u.d, 16'h0};
    endcase
    r = rs[31:16];
    s = rs[15:0];
    c = (u.cin == c_one) || ((u.cin == c_flag) && model_flags.carry);
    sres = 0;
    // signed sums give overflow, 17-bit sums give carry
    case (u.func)
      f_add: begin
        tot  = {1'b0, r} + {1'b0, s} + 17'(c);
        sres = int'($signed(r)) + int'($signed(s)) + int'(c);
      end
      f_subr: begin
        tot  = {1'b0, s} + {1'b0, ~r} + 17'(c);
        sres = int'($signed(s)) - int'($signed(r)) - 1 + int'(c);
      end
      f_subs: begin
        tot  = {1'b0, r} + {1'b0, ~s} + 17'(c);
        sres = int'($signed(r)) - int'($signed(s)) - 1 + int'(c);
      end
      f_or:    tot = {1'b0, r | s};
      f_and:   tot = {1'b0, r & s};
      f_xor:   tot = {1'b0, r ^ s};
      default: tot = {1'b0, s};
    endcase
    fv = tot[15:0];
    nf.carry = tot[16];
    nf.ovf   = (sres > 32767) || (sres < -32768);
    // right shifts fill from zero, F sign or the stored carry
    fill_bit = (u.fill == s_sign) ? fv[15] : ((u.fill == s_carry) && model_flags.carry);
    yv    = fv;
    q_new = model_q;
    case (u.dest)
      d_load_q: q_new = fv;
      d_shr:    yv = {fill_bit, fv[15:1]};
      d_shl:    yv = fv << 1;
      // F and Q move right as one 32-bit word
      d_dshr:   {yv, q_new} = {fill_bit, fv, model_q[15:1]};
      default:  ;
    endcase
    nf.zero = (yv == 16'h0);
    nf.sign = yv[15];
    // Q and flag words on the bus are from before this update
    case (u.bus)
      b_result: exp.data = yv;
      b_q:      exp.data = model_q;
      b_flags:  exp.data = {12'h0, model_flags};
      default:  exp.data = u.d;
    endcase
    exp.flags = u.set_flags ? nf : model_flags;
    if (u.set_flags) begin
      model_flags = nf;
    end
    model_q = q_new;
  endtask

  initial begin : stimulus
    alu_uop_t next_uop;
    word_t    next_a;
    word_t    next_b;
    word_t    gap;
    bus_out_t exp;
    int       sent;
    sent        = 0;
    model_q     = '0;
    model_flags = '0;
    @(negedge rst);
    while (sent < num_uops) begin
      @(posedge aluclk);
      // about one cycle in four is left idle
      take_bits(2, gap);
      if (gap[1:0] == 2'b00) begin
        uop_valid <= 1'b0;
      end else begin
        random_uop(next_uop, next_a, next_b);
        model_uop(next_uop, next_a, next_b, exp);
        expected.push_back(exp);
        uop_valid <= 1'b1;
        uop       <= next_uop;
        a         <= next_a;
        b         <= next_b;
        sent++;
      end
    end
    @(posedge aluclk);
    uop_valid <= 1'b0;
    // let the last results drain
    while (expected.size() != 0) begin
      @(posedge aluclk);
    end
    repeat (3) @(posedge aluclk);
    $display("Test completed successfully");
    $finish;
  end

  // outputs are compared half a cycle after the edge that moves them
  always @(negedge aluclk) begin : check_outputs
    bus_out_t exp;
    if (!rst && bus_valid) begin
      if (expected.size() == 0) begin
        stop_on_error("bus_valid rose with no microinstruction pending");
      end else begin
        exp = expected.pop_front();
        assert (bus_out.data == exp.data) else
          stop_on_error($sformatf("MISMATCH at %0t: bus data %h, expected %h",
                                  $time, bus_out.data, exp.data));
        assert (bus_out.flags == exp.flags) else
          stop_on_error($sformatf("MISMATCH at %0t: flags %b, expected %b",
                                  $time, bus_out.flags, exp.flags));
      end
    end
  end

  always @(posedge aluclk) begin : watchdog
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      stop_on_error($sformatf("timeout after %0d cycles", cycle_count));
    end
  end

endmodule

/* filelist.f */
source/alu_data_pkg.sv
source/alu_ops_pkg.sv
source/alu_core.sv
source/alu_shift_q.sv
source/alu_status.sv
source/alu_outmux.sv
source/alu_top.sv
bench/alu_clock.sv
bench/alu_properties.sv
bench/alu_tb.sv

/* run.sh */
#!/bin/sh
# builds the ALU testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module alu_tb -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Valu_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi
exit 0
